/* build.f */
source/x25519_pkg.sv
source/field_add.sv
source/field_freeze.sv
source/field_alu.sv
source/wb_field_regs.sv
source/x25519_field_unit.sv
test/x25519_field_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and decides pass or fail from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module x25519_field_unit_tb -f build.f -o x25519_field_unit_sim \
	&& ./obj_dir/x25519_field_unit_sim > sim.log 2>&1 \
	|| { echo "build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

/* test/x25519_field_unit_tb.sv */
module x25519_field_unit_tb;
	import x25519_pkg::*;

	localparam int RANDOM_OPS     = 200;                        // operations in the random test.
	localparam int NUM_OPS        = 7 + 5 + RANDOM_OPS + 1;     // every operation the run starts.
	localparam int TIMEOUT_CYCLES = NUM_OPS * 60 + 1000;        // generous bound on run length.
	localparam int ACK_LIMIT      = 4;                          // cycles allowed for one ack.
	localparam int POLL_LIMIT     = 20;                         // status reads before giving up.
	localparam logic [511:0] P_WIDE = (512'd1 << 255) - 512'd19; // the prime with room for the model.
	localparam logic [FIELD_BITS-1:0] P_REF    = P_WIDE[FIELD_BITS-1:0];
	localparam logic [FIELD_BITS-1:0] ALL_ONES = '1;            // 2^256 - 1.

	logic        clk;
	logic        rst_n;
	wb_req_t     wb_req;      // bus master side, driven on the falling edge.
	wb_rsp_t     wb_rsp;
	int          errors;      // failed checks over the whole run.
	int          test_mark;   // error count when the current test began.
	int          pass_count;
	int          fail_count;
	int          cycle_count;

	x25519_field_unit x25519_field_unit_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always #50 clk = ~clk; // period of 100.

	// the run may not outlast the bound worked out from the number of operations.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// plain modular arithmetic with room for the carry.
	function automatic logic [FIELD_BITS-1:0] ref_reduce(input logic [FIELD_BITS-1:0] a);
		logic [511:0] r;
		r = {256'd0, a} % P_WIDE;
		return r[FIELD_BITS-1:0];
	endfunction

	function automatic logic [FIELD_BITS-1:0] ref_add(input logic [FIELD_BITS-1:0] a,
		input logic [FIELD_BITS-1:0] b);
		logic [511:0] r;
		r = ({256'd0, a} + {256'd0, b}) % P_WIDE; // the sum can reach 2^257 - 2.
		return r[FIELD_BITS-1:0];
	endfunction

	function automatic logic [FIELD_BITS-1:0] rand_elem();
		logic [FIELD_BITS-1:0] v;
		for (int i = 0; i < ELEM_WORDS; i++) begin
			v[i*WORD_BITS +: WORD_BITS] = $urandom;
		end
		if ($urandom % 4 == 0) begin
			v[FIELD_BITS-1 -: WORD_BITS] = 32'hffff_ffff; // lands above 2p now and then.
		end
		return v;
	endfunction

	function automatic logic [WORD_BITS-1:0] ctrl_word(input field_op_t op);
		logic [WORD_BITS-1:0] w;
		w                 = '0;
		w[CTRL_START_BIT] = 1'b1;
		w[CTRL_OP_BIT]    = op;
		return w;
	endfunction

	task automatic check_word(input logic [WORD_BITS-1:0] got, input logic [WORD_BITS-1:0] exp,
		input string name);
		if (got !== exp) begin
			$display("Error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_elem(input logic [FIELD_BITS-1:0] got, input logic [FIELD_BITS-1:0] exp,
		input string name);
		if (got !== exp) begin
			$display("Error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// one classic cycle holds the request until ack and then drops it.
	task automatic wb_write(input logic [ADR_BITS-1:0] adr, input logic [WORD_BITS-1:0] data);
		@(negedge clk);
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = 1'b1;
		wb_req.adr   = adr;
		wb_req.wdata = data;
		for (int n = 0; n < ACK_LIMIT; n++) begin
			@(negedge clk);
			if (wb_rsp.ack) break; // ack is stable half a cycle after the edge.
		end
		if (!wb_rsp.ack) begin
			$display("no acknowledge for the write to word %0d within %0d cycles", adr, ACK_LIMIT);
			errors++;
		end
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic wb_read(input logic [ADR_BITS-1:0] adr, output logic [WORD_BITS-1:0] data);
		@(negedge clk);
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = 1'b0;
		wb_req.adr   = adr;
		wb_req.wdata = '0;
		for (int n = 0; n < ACK_LIMIT; n++) begin
			@(negedge clk);
			if (wb_rsp.ack) break;
		end
		if (!wb_rsp.ack) begin
			$display("no acknowledge for the read of word %0d within %0d cycles", adr, ACK_LIMIT);
			errors++;
		end
		data       = wb_rsp.rdata; // read data comes with the ack.
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic write_elem(input logic [ADR_BITS-1:0] base, input logic [FIELD_BITS-1:0] value);
		for (int i = 0; i < ELEM_WORDS; i++) begin
			wb_write(base + ADR_BITS'(i), value[i*WORD_BITS +: WORD_BITS]); // low word first.
		end
	endtask

	task automatic read_elem(input logic [ADR_BITS-1:0] base, output logic [FIELD_BITS-1:0] value);
		logic [WORD_BITS-1:0] word;
		for (int i = 0; i < ELEM_WORDS; i++) begin
			wb_read(base + ADR_BITS'(i), word);
			value[i*WORD_BITS +: WORD_BITS] = word;
		end
	endtask

	// polls status until done and requires busy to stay up while done is low.
	task automatic wait_done();
		logic [WORD_BITS-1:0] status;
		status = '0;
		for (int n = 0; n < POLL_LIMIT; n++) begin
			wb_read(REG_STATUS, status);
			if (status[STATUS_DONE_BIT] || !status[STATUS_BUSY_BIT]) break;
		end
		if (status[STATUS_DONE_BIT]) begin
			check_word(status, 32'h2, "status"); // done set and busy cleared together.
		end else if (!status[STATUS_BUSY_BIT]) begin
			$display("status dropped busy before done was set");
			errors++;
		end else begin
			$display("operation did not finish within %0d status reads", POLL_LIMIT);
			errors++;
		end
	endtask

	task automatic verify_op(input field_op_t op, input logic [FIELD_BITS-1:0] a,
		input logic [FIELD_BITS-1:0] b);
		logic [FIELD_BITS-1:0] got;
		logic [FIELD_BITS-1:0] exp;
		write_elem(REG_A_BASE, a);
		if (op == OP_ADD) begin
			write_elem(REG_B_BASE, b); // reduce never looks at b.
		end
		wb_write(REG_CTRL, ctrl_word(op));
		wait_done();
		read_elem(REG_R_BASE, got);
		exp = (op == OP_ADD) ? ref_add(a, b) : ref_reduce(a);
		check_elem(got, exp, (op == OP_ADD) ? "add_result" : "reduce_result");
	endtask

	task automatic finish_test(input string name);
		int n;
		n = errors - test_mark;
		if (n == 0) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
		test_mark = errors;
	endtask

	task automatic test_reset_regs();
		logic [WORD_BITS-1:0]  word;
		logic [FIELD_BITS-1:0] a_val;
		logic [FIELD_BITS-1:0] b_val;
		logic [FIELD_BITS-1:0] got;
		wb_read(REG_STATUS, word);
		check_word(word, '0, "status");
		read_elem(REG_R_BASE, got);
		check_elem(got, '0, "result");
		a_val = rand_elem();
		b_val = rand_elem();
		write_elem(REG_A_BASE, a_val);
		write_elem(REG_B_BASE, b_val);
		read_elem(REG_A_BASE, got);
		check_elem(got, a_val, "operand_a");
		read_elem(REG_B_BASE, got);
		check_elem(got, b_val, "operand_b");
		write_elem(REG_R_BASE, a_val); // result words are read only.
		read_elem(REG_R_BASE, got);
		check_elem(got, '0, "result");
		wb_read(5'd30, word);          // nothing is mapped here.
		check_word(word, '0, "unmapped_rdata");
		finish_test("reset_regs");
	endtask

	task automatic test_reduce_edges();
		logic [FIELD_BITS-1:0] vals [0:6];
		vals[0] = '0;
		vals[1] = P_REF - 256'd1;
		vals[2] = P_REF;
		vals[3] = P_REF + 256'd1;
		vals[4] = (P_REF << 1) - 256'd1;
		vals[5] = P_REF << 1;          // 2p still fits in 256 bits.
		vals[6] = ALL_ONES;
		for (int i = 0; i < 7; i++) begin
			verify_op(OP_REDUCE, vals[i], '0);
		end
		finish_test("reduce_edges");
	endtask

	task automatic test_add_carries();
		logic [FIELD_BITS-1:0] a_vals [0:4];
		logic [FIELD_BITS-1:0] b_vals [0:4];
		a_vals[0] = (256'd1 << 254) + 256'd5;  // crosses 2^255.
		b_vals[0] = (256'd1 << 254) + 256'd7;
		a_vals[1] = P_REF - 256'd1;            // lands exactly on p.
		b_vals[1] = 256'd1;
		a_vals[2] = ALL_ONES - 256'd9;         // crosses 2^256, one fold.
		b_vals[2] = 256'd20;
		a_vals[3] = ALL_ONES;                  // exactly 2^256.
		b_vals[3] = 256'd1;
		a_vals[4] = ALL_ONES;                  // the fold carries again.
		b_vals[4] = ALL_ONES;
		for (int i = 0; i < 5; i++) begin
			verify_op(OP_ADD, a_vals[i], b_vals[i]);
		end
		finish_test("add_carries");
	endtask

	task automatic test_random_ops();
		field_op_t op;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			op = ($urandom % 2 == 0) ? OP_ADD : OP_REDUCE;
			verify_op(op, rand_elem(), rand_elem());
		end
		finish_test("random_ops");
	endtask

	task automatic test_status_protocol();
		logic [WORD_BITS-1:0]  status;
		logic [FIELD_BITS-1:0] a_val;
		logic [FIELD_BITS-1:0] b_val;
		logic [FIELD_BITS-1:0] got;
		a_val = rand_elem();
		b_val = rand_elem();
		write_elem(REG_A_BASE, a_val);
		write_elem(REG_B_BASE, b_val);
		wb_write(REG_CTRL, ctrl_word(OP_ADD));
		wb_read(REG_STATUS, status);
		check_word(status, 32'h1, "status"); // busy, done not yet set.
		wb_write(REG_CTRL, ctrl_word(OP_REDUCE)); // arrives while busy and must be ignored.
		wait_done();
		read_elem(REG_R_BASE, got);
		check_elem(got, ref_add(a_val, b_val), "add_result");
		finish_test("status_protocol");
	endtask

	initial begin
		void'($urandom(32'h2369));
		clk         = 1'b0;
		rst_n       = 1'b0;
		wb_req      = '0;
		errors      = 0;
		test_mark   = 0;
		pass_count  = 0;
		fail_count  = 0;
		cycle_count = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset_regs();
		test_reduce_edges();
		test_add_carries();
		test_random_ops();
		test_status_protocol();
		$display("tests ok %0d, tests failed %0d, checks failed %0d", pass_count, fail_count, errors);
		if (errors == 0 && fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* source/x25519_field_unit.sv */
module x25519_field_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  x25519_pkg::wb_req_t   wb_req,
	output x25519_pkg::wb_rsp_t   wb_rsp
);
	import x25519_pkg::*;

	alu_req_t alu_req; // operands and start pulse from the register file.
	alu_rsp_t alu_rsp; // canonical result and completion pulse.

	// the register front end owns the bus and the busy state.
	wb_field_regs wb_field_regs_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.alu_req (alu_req),
		.alu_rsp (alu_rsp)
	);

	// adder and freeze pipelines.
	field_alu field_alu_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (alu_req),
		.rsp   (alu_rsp)
	);

endmodule

/* source/wb_field_regs.sv */
module wb_field_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  x25519_pkg::wb_req_t    wb_req,
	output x25519_pkg::wb_rsp_t    wb_rsp,
	output x25519_pkg::alu_req_t   alu_req,
	input  x25519_pkg::alu_rsp_t   alu_rsp
);
	import x25519_pkg::*;

	logic [ELEM_WORDS-1:0][WORD_BITS-1:0] a_words; // operand a, word 0 is least significant.
	logic [ELEM_WORDS-1:0][WORD_BITS-1:0] b_words; // operand b.
	logic [ELEM_WORDS-1:0][WORD_BITS-1:0] r_words; // last captured result.

	logic                              ack_q;     // single cycle acknowledge.
	logic [WORD_BITS-1:0]              rdata_q;   // read data, valid with ack.
	logic                              req_hit;   // new bus request this cycle.
	logic [WORD_SEL_BITS-1:0]          word_sel;  // word inside an element.
	logic [ADR_BITS-WORD_SEL_BITS-1:0] bank;      // which element the address falls in.
	logic                              wr_hit;    // acknowledged write this cycle.
	logic                              start_req; // accepted start.
	logic [WORD_BITS-1:0]              read_word; // decoded read data.
	logic                              start_q;   // start pulse towards the alu.
	logic                              busy;
	logic                              done;
	field_op_t                         op_q;

	// the request stays up during the ack cycle, so it must not hit twice.
	assign req_hit  = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_hit   = req_hit && wb_req.we;
	assign word_sel = wb_req.adr[WORD_SEL_BITS-1:0];
	assign bank     = wb_req.adr[ADR_BITS-1:WORD_SEL_BITS];

	// a start that arrives while busy is acknowledged but goes nowhere.
	assign start_req = wr_hit && (wb_req.adr == REG_CTRL) &&
		wb_req.wdata[CTRL_START_BIT] && !busy;

	// unmapped addresses read as zero.
	always_comb begin
		read_word = '0;
		if (bank == REG_A_BASE[ADR_BITS-1:WORD_SEL_BITS]) begin
			read_word = a_words[word_sel];
		end else if (bank == REG_B_BASE[ADR_BITS-1:WORD_SEL_BITS]) begin
			read_word = b_words[word_sel];
		end else if (bank == REG_R_BASE[ADR_BITS-1:WORD_SEL_BITS]) begin
			read_word = r_words[word_sel];
		end else if (wb_req.adr == REG_CTRL) begin
			read_word[CTRL_OP_BIT] = op_q;     // the opcode reads back, start does not.
		end else if (wb_req.adr == REG_STATUS) begin
			read_word[STATUS_BUSY_BIT] = busy;
			read_word[STATUS_DONE_BIT] = done;
		end
	end

	// the bus side handles ack, read data and operand writes.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q   <= 1'b0;
			rdata_q <= '0;
			a_words <= '0;
			b_words <= '0;
			op_q    <= OP_ADD;
		end else begin
			ack_q   <= req_hit;                                   // no wait states.
			rdata_q <= (req_hit && !wb_req.we) ? read_word : '0;
			if (wr_hit && bank == REG_A_BASE[ADR_BITS-1:WORD_SEL_BITS]) begin
				a_words[word_sel] <= wb_req.wdata;
			end
			if (wr_hit && bank == REG_B_BASE[ADR_BITS-1:WORD_SEL_BITS]) begin
				b_words[word_sel] <= wb_req.wdata;
			end
			if (wr_hit && wb_req.adr == REG_CTRL && !busy) begin
				op_q <= field_op_t'(wb_req.wdata[CTRL_OP_BIT]); // held for the whole operation.
			end
		end
	end

	// the operation side handles the start pulse, busy, done and result capture.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
			busy    <= 1'b0;
			done    <= 1'b0;
			r_words <= '0;
		end else begin
			start_q <= start_req;                  // high in the ack cycle of the start write.
			if (start_req) begin
				busy <= 1'b1;
				done <= 1'b0;                      // a new start clears the old done.
			end else if (alu_rsp.valid) begin
				busy    <= 1'b0;
				done    <= 1'b1;
				r_words <= alu_rsp.result;
			end
		end
	end

	assign wb_rsp.ack   = ack_q;
	assign wb_rsp.rdata = rdata_q;

	// operands stay stable after the start since the alu samples them on the pulse.
	assign alu_req.valid = start_q;
	assign alu_req.op    = op_q;
	assign alu_req.a     = a_words;
	assign alu_req.b     = b_words;

endmodule

/* source/field_alu.sv */
module field_alu (
	input  logic                   clk,
	input  logic                   rst_n,
	input  x25519_pkg::alu_req_t   req,
	output x25519_pkg::alu_rsp_t   rsp
);
	import x25519_pkg::*;

	logic                  add_en;       // request enters the adder.
	logic                  add_valid;    // adder result ready for the freeze stage.
	logic [FIELD_BITS-1:0] add_out;      // folded sum, not yet canonical.
	logic                  reduce_en;    // request skips the adder.
	logic                  freeze_en;    // something enters the freeze stage.
	logic [FIELD_BITS-1:0] freeze_in;    // adder output or operand a.
	logic                  freeze_valid; // canonical result ready.
	logic [FIELD_BITS-1:0] freeze_out;

	// opcode decides where the request enters the pipe.
	assign add_en    = req.valid && (req.op == OP_ADD);
	assign reduce_en = req.valid && (req.op == OP_REDUCE);

	field_add field_add_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (add_en),
		.a         (req.a),
		.b         (req.b),
		.out_valid (add_valid),
		.out       (add_out)
	);

	// the front end keeps a single operation outstanding, so an adder result
	// and a direct reduce never meet at this mux.
	assign freeze_en = add_valid || reduce_en;
	assign freeze_in = add_valid ? add_out : req.a; // the adder wins when it has data.

	field_freeze field_freeze_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (freeze_en),
		.a         (freeze_in),
		.out_valid (freeze_valid),
		.out       (freeze_out)
	);

	// completion is the freeze output pulse, which comes four cycles after an add and two after a reduce.
	assign rsp.valid  = freeze_valid;
	assign rsp.result = freeze_out;

endmodule

/* source/field_freeze.sv */
module field_freeze (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                en,
	input  logic [x25519_pkg::FIELD_BITS-1:0]   a,
	output logic                                out_valid,
	output logic [x25519_pkg::FIELD_BITS-1:0]   out
);
	import x25519_pkg::*;

	// everything stage 2 needs to pick the canonical value.
	typedef struct packed {
		logic [FIELD_BITS-1:0] orig;      // the input itself.
		logic [FIELD_BITS-1:0] sub_p;     // input minus p.
		logic [FIELD_BITS-1:0] sub_2p;    // input minus 2p.
		logic                  borrow_p;  // input was below p.
		logic                  borrow_2p; // input was below 2p.
	} freeze_stage_t;

	logic                stage1_valid; // a candidate set sits in stage 1.
	logic [FIELD_BITS:0] diff_p;       // borrow lands in the top bit.
	logic [FIELD_BITS:0] diff_2p;      // borrow lands in the top bit.
	freeze_stage_t       stage1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage1_valid <= 1'b0;
			out_valid    <= 1'b0;
		end else begin
			stage1_valid <= en;
			out_valid    <= stage1_valid;
		end
	end

	// both subtractions run side by side since 2^256 is below 3p.
	always_comb begin
		diff_p  = {1'b0, a} - {1'b0, FIELD_P};
		diff_2p = {1'b0, a} - {1'b0, FIELD_2P};
	end

	always_ff @(posedge clk) begin
		if (en) begin
			stage1.orig      <= a;
			stage1.sub_p     <= diff_p[FIELD_BITS-1:0];
			stage1.sub_2p    <= diff_2p[FIELD_BITS-1:0];
			stage1.borrow_p  <= diff_p[FIELD_BITS];
			stage1.borrow_2p <= diff_2p[FIELD_BITS];
		end
	end

	// the smallest candidate that did not borrow is the one inside [0, p).
	always_ff @(posedge clk) begin
		if (stage1_valid) begin
			if (!stage1.borrow_2p) begin
				out <= stage1.sub_2p; // input was in [2p, 2^256).
			end else if (!stage1.borrow_p) begin
				out <= stage1.sub_p;  // input was in [p, 2p).
			end else begin
				out <= stage1.orig;   // already canonical.
			end
		end
	end

endmodule

/* source/field_add.sv */
module field_add (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                en,
	input  logic [x25519_pkg::FIELD_BITS-1:0]   a,
	input  logic [x25519_pkg::FIELD_BITS-1:0]   b,
	output logic                                out_valid,
	output logic [x25519_pkg::FIELD_BITS-1:0]   out
);
	import x25519_pkg::*;

	logic                  stage1_valid; // a sum sits in the first stage.
	logic [FIELD_BITS:0]   stage1_sum;   // full sum with the carry out of bit 255.
	logic [FIELD_BITS-1:0] fold1_addend; // 38 when the raw sum carried, else zero.
	logic [FIELD_BITS:0]   fold1_sum;    // sum after the first fold.
	logic [FIELD_BITS-1:0] fold2_addend; // 38 when the first fold carried again.
	logic [FIELD_BITS-1:0] fold2_sum;    // final value, always below 2^256.

	// valid bits walk down the pipe with the data.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage1_valid <= 1'b0;
			out_valid    <= 1'b0;
		end else begin
			stage1_valid <= en;
			out_valid    <= stage1_valid;
		end
	end

	// stage 1 keeps the 257-bit sum so the carry is known in stage 2.
	always_ff @(posedge clk) begin
		if (en) begin
			stage1_sum <= {1'b0, a} + {1'b0, b};
		end
	end

	// a carry out of bit 255 is worth 2^256, which is 38 mod p.
	always_comb begin
		fold1_addend = stage1_sum[FIELD_BITS] ? FOLD_CONST : '0; // fold the first carry.
		fold1_sum    = {1'b0, stage1_sum[FIELD_BITS-1:0]} + {1'b0, fold1_addend};
		// if this carried, the low bits are below 38, so one more fold cannot carry.
		fold2_addend = fold1_sum[FIELD_BITS] ? FOLD_CONST : '0;
		fold2_sum    = fold1_sum[FIELD_BITS-1:0] + fold2_addend;
	end

	// stage 2 output register, congruent to a + b but not yet canonical.
	always_ff @(posedge clk) begin
		if (stage1_valid) begin
			out <= fold2_sum;
		end
	end

endmodule

/* source/x25519_pkg.sv */
package x25519_pkg;

	localparam int FIELD_BITS    = 256; // width of one field element.
	localparam int WORD_BITS     = 32;  // width of the wishbone data bus.
	localparam int ELEM_WORDS    = 8;   // bus words per field element.
	localparam int ADR_BITS      = 5;   // word address width of the register file.
	localparam int WORD_SEL_BITS = 3;   // low address bits that pick a word inside an element.

	// the freeze stage subtracts the prime 2^255 - 19 and its double.
	localparam logic [FIELD_BITS-1:0] FIELD_P =
		256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;
	localparam logic [FIELD_BITS-1:0] FIELD_2P =
		256'hffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffda;
	localparam logic [FIELD_BITS-1:0] FOLD_CONST = 256'd38; // 2^256 mod p.

	typedef enum logic [0:0] {
		OP_ADD    = 1'b0, // canonical (a + b) mod p.
		OP_REDUCE = 1'b1  // canonical a mod p.
	} field_op_t;

	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [ADR_BITS-1:0] adr;   // word address, not byte address.
		logic [WORD_BITS-1:0] wdata;
	} wb_req_t;

	typedef struct packed {
		logic                 ack;
		logic [WORD_BITS-1:0] rdata;
	} wb_rsp_t;

	typedef struct packed {
		logic                  valid; // single cycle start pulse.
		field_op_t             op;
		logic [FIELD_BITS-1:0] a;
		logic [FIELD_BITS-1:0] b;
	} alu_req_t;

	typedef struct packed {
		logic                  valid; // single cycle completion pulse.
		logic [FIELD_BITS-1:0] result;
	} alu_rsp_t;

	localparam logic [ADR_BITS-1:0] REG_A_BASE = 5'd0;  // operand a, least significant word first.
	localparam logic [ADR_BITS-1:0] REG_B_BASE = 5'd8;  // operand b.
	localparam logic [ADR_BITS-1:0] REG_R_BASE = 5'd16; // result, read only.
	localparam logic [ADR_BITS-1:0] REG_CTRL   = 5'd24; // start and opcode.
	localparam logic [ADR_BITS-1:0] REG_STATUS = 5'd25; // busy and done, read only.

	localparam int CTRL_START_BIT  = 0;
	localparam int CTRL_OP_BIT     = 1;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

endpackage
